/* Bender.yml */
package:
  name: control_unit

sources:
  - files:
      - rtl/rv_isa_pkg.sv
      - rtl/rv_ctrl_pkg.sv
      - rtl/instr_class_if.sv
      - rtl/instr_class_decode.sv
      - rtl/exec_ctrl_decode.sv
      - rtl/access_ctrl_decode.sv
      - rtl/decode_stage_reg.sv
      - rtl/control_unit.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_control_unit.sv

/* files.f */
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/instr_class_if.sv
rtl/instr_class_decode.sv
rtl/exec_ctrl_decode.sv
rtl/access_ctrl_decode.sv
rtl/decode_stage_reg.sv
rtl/control_unit.sv
tests/tb_clock_gen.sv
tests/tb_control_unit.sv

/* rtl/access_ctrl_decode.sv */
`timescale 1ns/100ps

module access_ctrl_decode (
    instr_class_if.sink               cls,
    output rv_ctrl_pkg::access_ctrl_t access
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic csr_swap;

    assign csr_swap = cls.funct3 inside {f3_csrrw, f3_csrrwi}; // CSRRW and CSRRWI.

    always_comb begin
        access = '0;
        case (cls.op_class)
            cls_lui, cls_auipc, cls_jal: access.rd_write = 1'b1;
            cls_jalr, cls_op_imm: begin
                access.rs1_read = 1'b1;
                access.rd_write = 1'b1;
            end
            cls_branch: begin
                access.rs1_read = 1'b1;
                access.rs2_read = 1'b1;
            end
            cls_op: begin
                access.rs1_read = 1'b1;
                access.rs2_read = 1'b1;
                access.rd_write = 1'b1;
            end
            cls_load: begin
                access.rs1_read        = 1'b1;
                access.rd_write        = 1'b1;
                access.mem_read        = 1'b1;
                access.mem_width       = mem_width_t'(cls.funct3[1:0]);
                access.mem_zero_extend = cls.funct3[2];
            end
            cls_store: begin
                access.rs1_read  = 1'b1;
                access.rs2_read  = 1'b1;
                access.mem_write = 1'b1;
                access.mem_width = mem_width_t'(cls.funct3[1:0]);
            end
            cls_fence_i: access.mem_fence = 1'b1;
            cls_csr: begin
                // A swap into x0 skips the CSR read, a set or clear with x0 skips the write.
                access.rs1_read  = !cls.funct3[2];
                access.csr_read  = csr_swap ? |cls.rd : 1'b1;
                access.csr_write = csr_swap ? 1'b1 : |cls.rs1;
                access.rd_write  = csr_swap ? |cls.rd : 1'b1;
                access.csr_src   = csr_src_t'(cls.funct3[2]);
                case (cls.funct3)
                    f3_csrrs, f3_csrrsi: access.csr_write_op = csr_op_rs;
                    f3_csrrc, f3_csrrci: access.csr_write_op = csr_op_rc;
                    default:             access.csr_write_op = csr_op_rw;
                endcase
            end
            default: ;
        endcase
    end

    no_read_and_write: assert property (@(posedge cls.clk) disable iff (!cls.rst_n)
        !(access.mem_read && access.mem_write));

endmodule

/* rtl/control_unit.sv */
`timescale 1ns/100ps

module control_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  rv_isa_pkg::instr_t        instr,
    output logic                      ctrl_valid,
    output logic                      ctrl_legal,
    output rv_ctrl_pkg::exec_ctrl_t   exec,
    output rv_ctrl_pkg::access_ctrl_t access
);
    import rv_ctrl_pkg::*;

    exec_ctrl_t   exec_d;
    access_ctrl_t access_d;

    instr_class_if cls_bus (.clk(clk), .rst_n(rst_n));

    instr_class_decode u_class (.instr(instr), .cls(cls_bus.source));

    exec_ctrl_decode u_exec (.cls(cls_bus.sink), .exec(exec_d));

    access_ctrl_decode u_access (.cls(cls_bus.sink), .access(access_d));

    decode_stage_reg #(.payload_t(exec_ctrl_t)) u_exec_reg (
        .clk  (clk),
        .rst_n(rst_n),
        .load (instr_valid),
        .d    (exec_d),
        .q    (exec)
    );

    decode_stage_reg #(.payload_t(access_ctrl_t)) u_access_reg (
        .clk  (clk),
        .rst_n(rst_n),
        .load (instr_valid),
        .d    (access_d),
        .q    (access)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_valid <= 1'b0;
            ctrl_legal <= 1'b0;
        end else begin
            ctrl_valid <= instr_valid; // One output cycle per strobe.
            if (instr_valid) ctrl_legal <= (cls_bus.op_class != cls_illegal);
        end
    end

    // The stage registers load on the same edge that raises ctrl_valid.
    valid_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |=> ctrl_valid && exec == $past(exec_d) && access == $past(access_d));
    held_without_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_valid |=> !ctrl_valid && $stable(exec) && $stable(access));

endmodule

/* rtl/decode_stage_reg.sv */
`timescale 1ns/100ps

module decode_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  payload_t d,
    output payload_t q
);

    // The payload holds its value until the next load.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

endmodule

/* rtl/exec_ctrl_decode.sv */
`timescale 1ns/100ps

module exec_ctrl_decode (
    instr_class_if.sink               cls,
    output rv_ctrl_pkg::exec_ctrl_t   exec
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    always_comb begin
        exec = '0;
        case (cls.op_class)
            cls_lui: begin
                exec.imm_fmt  = imm_u;
                exec.alu_src1 = src1_zero;
                exec.alu_src2 = src2_imm;
            end
            cls_auipc: begin
                exec.imm_fmt  = imm_u;
                exec.alu_src1 = src1_pc;
                exec.alu_src2 = src2_imm;
            end
            cls_jal, cls_jalr: begin
                // The ALU forms the link address pc + 4.
                exec.imm_fmt       = (cls.op_class == cls_jal) ? imm_j : imm_i;
                exec.alu_src1      = src1_pc;
                exec.alu_src2      = src2_four;
                exec.branch_op     = br_always;
                exec.branch_pc_src = (cls.op_class == cls_jal) ? br_pc_imm : br_pc_reg;
            end
            cls_branch: begin
                exec.imm_fmt     = imm_b;
                exec.alu_sub_sra = 1'b1;
                case (cls.funct3)
                    f3_beq: exec.branch_op = br_zero;
                    f3_bne: exec.branch_op = br_non_zero;
                    f3_blt: begin
                        exec.alu_op    = alu_slt;
                        exec.branch_op = br_non_zero;
                    end
                    f3_bge: begin
                        exec.alu_op    = alu_slt;
                        exec.branch_op = br_zero;
                    end
                    f3_bltu: begin
                        exec.alu_op    = alu_sltu;
                        exec.branch_op = br_non_zero;
                    end
                    f3_bgeu: begin
                        exec.alu_op    = alu_sltu;
                        exec.branch_op = br_zero;
                    end
                    default: ;
                endcase
            end
            cls_load: begin
                exec.imm_fmt  = imm_i;
                exec.alu_src2 = src2_imm;
            end
            cls_store: begin
                exec.imm_fmt  = imm_s;
                exec.alu_src2 = src2_imm;
            end
            cls_op_imm: begin
                exec.imm_fmt     = (cls.funct3 inside {f3_sll, f3_srl_sra}) ? imm_shamt : imm_i;
                exec.alu_op      = alu_op_t'(cls.funct3);
                exec.alu_sub_sra = (cls.funct3 == f3_srl_sra && cls.alt) ||
                                   cls.funct3 inside {f3_slt, f3_sltu};
                exec.alu_src2    = src2_imm;
            end
            cls_op: begin
                exec.alu_op      = alu_op_t'(cls.funct3);
                exec.alu_sub_sra = cls.alt || cls.funct3 inside {f3_slt, f3_sltu}; // Alt is SUB or SRA.
            end
            cls_csr: exec.imm_fmt = cls.funct3[2] ? imm_zimm : imm_none;
            default: ;
        endcase
    end

    // Only JALR takes its target from a register.
    reg_target_jumps: assert property (@(posedge cls.clk) disable iff (!cls.rst_n)
        exec.branch_pc_src == br_pc_reg |-> exec.branch_op == br_always);

endmodule

/* rtl/instr_class_decode.sv */
`timescale 1ns/100ps

module instr_class_decode (
    input  rv_isa_pkg::instr_t instr,
    instr_class_if.source      cls
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [6:0]  opcode;
    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic [11:0] funct12;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign funct12 = instr[31:20];

    assign cls.funct3 = funct3;
    assign cls.alt    = instr[30];
    assign cls.rs1    = instr[19:15];
    assign cls.rd     = instr[11:7];

    always_comb begin
        cls.op_class = cls_illegal;
        case (opcode)
            opc_lui:   cls.op_class = cls_lui;
            opc_auipc: cls.op_class = cls_auipc;
            opc_jal:   cls.op_class = cls_jal;
            opc_jalr: begin
                if (funct3 == f3_jalr) cls.op_class = cls_jalr;
            end
            opc_branch: begin
                if (funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu})
                    cls.op_class = cls_branch;
            end
            opc_load: begin
                if (funct3 inside {f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu}) cls.op_class = cls_load;
            end
            opc_store: begin
                if (funct3 inside {f3_sb, f3_sh, f3_sw}) cls.op_class = cls_store;
            end
            opc_op_imm: begin
                // Shift immediates carry funct7 in the upper bits; the rest take any immediate.
                if (funct3 == f3_sll) begin
                    if (funct7 == funct7_base) cls.op_class = cls_op_imm;
                end else if (funct3 == f3_srl_sra) begin
                    if (funct7 inside {funct7_base, funct7_alt}) cls.op_class = cls_op_imm;
                end else begin
                    cls.op_class = cls_op_imm;
                end
            end
            opc_op: begin
                if (funct7 == funct7_base ||
                    (funct7 == funct7_alt && funct3 inside {f3_add_sub, f3_srl_sra}))
                    cls.op_class = cls_op;
            end
            opc_misc_mem: begin
                if (funct3 == f3_fence) cls.op_class = cls_fence;
                else if (funct3 == f3_fence_i) cls.op_class = cls_fence_i;
            end
            opc_system: begin
                if (funct3 == f3_priv) begin
                    if (funct12 inside {f12_ecall, f12_ebreak, f12_mret, f12_wfi} &&
                        cls.rs1 == '0 && cls.rd == '0)
                        cls.op_class = cls_system;
                end else if (funct3 inside {f3_csrrw, f3_csrrs, f3_csrrc,
                                            f3_csrrwi, f3_csrrsi, f3_csrrci}) begin
                    cls.op_class = cls_csr;
                end
            end
            default: ;
        endcase
    end

    class_known: assert property (@(posedge cls.clk) disable iff (!cls.rst_n)
        !$isunknown(instr) |-> !$isunknown(cls.op_class));

endmodule

/* rtl/instr_class_if.sv */
`timescale 1ns/100ps

interface instr_class_if (
    input logic clk,
    input logic rst_n
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    instr_class_t op_class;
    logic [2:0]   funct3;
    logic         alt;  // Instruction bit 30.
    reg_idx_t     rs1;
    reg_idx_t     rd;

    modport source (input clk, rst_n, output op_class, funct3, alt, rs1, rd);
    modport sink (input clk, rst_n, op_class, funct3, alt, rs1, rd);

endinterface

/* rtl/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    // Zero is the neutral value of every enum, so an all-zero struct does nothing.
    typedef enum logic [3:0] {
        cls_illegal,
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_op_imm,
        cls_op,
        cls_fence,
        cls_fence_i,
        cls_system,
        cls_csr
    } instr_class_t;

    typedef enum logic [2:0] {
        imm_none, imm_i, imm_s, imm_b, imm_u, imm_j, imm_shamt, imm_zimm
    } imm_fmt_t;

    // Ordered like funct3 of OP, so the ALU operation is a plain cast.
    typedef enum logic [2:0] {
        alu_add_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor_op, alu_srl_sra, alu_or_op, alu_and_op
    } alu_op_t;

    typedef enum logic [1:0] {src1_reg, src1_pc, src1_zero} alu_src1_t;
    typedef enum logic [1:0] {src2_reg, src2_imm, src2_four} alu_src2_t;
    typedef enum logic [1:0] {br_never, br_zero, br_non_zero, br_always} branch_op_t;
    typedef enum logic {br_pc_imm, br_pc_reg} branch_pc_src_t;
    typedef enum logic [1:0] {mem_byte, mem_half, mem_word} mem_width_t;
    typedef enum logic [1:0] {csr_op_rw, csr_op_rs, csr_op_rc} csr_write_op_t;
    typedef enum logic {csr_src_reg, csr_src_imm} csr_src_t;

    typedef struct packed {
        imm_fmt_t       imm_fmt;
        alu_op_t        alu_op;
        logic           alu_sub_sra;
        alu_src1_t      alu_src1;
        alu_src2_t      alu_src2;
        branch_op_t     branch_op;
        branch_pc_src_t branch_pc_src;
    } exec_ctrl_t;

    typedef struct packed {
        logic          rs1_read;
        logic          rs2_read;
        logic          rd_write;
        logic          mem_read;
        logic          mem_write;
        mem_width_t    mem_width;
        logic          mem_zero_extend;
        logic          mem_fence;
        logic          csr_read;
        logic          csr_write;
        csr_write_op_t csr_write_op;
        csr_src_t      csr_src;
    } access_ctrl_t;

endpackage

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes, bits [6:0] of the instruction word.
    localparam logic [6:0] opc_lui      = 7'b0110111;
    localparam logic [6:0] opc_auipc    = 7'b0010111;
    localparam logic [6:0] opc_jal      = 7'b1101111;
    localparam logic [6:0] opc_jalr     = 7'b1100111;
    localparam logic [6:0] opc_branch   = 7'b1100011;
    localparam logic [6:0] opc_load     = 7'b0000011;
    localparam logic [6:0] opc_store    = 7'b0100011;
    localparam logic [6:0] opc_op_imm   = 7'b0010011;
    localparam logic [6:0] opc_op       = 7'b0110011;
    localparam logic [6:0] opc_misc_mem = 7'b0001111;
    localparam logic [6:0] opc_system   = 7'b1110011;

    localparam logic [2:0] f3_jalr    = 3'b000;
    localparam logic [2:0] f3_lb      = 3'b000;
    localparam logic [2:0] f3_lh      = 3'b001;
    localparam logic [2:0] f3_lw      = 3'b010;
    localparam logic [2:0] f3_lbu     = 3'b100;
    localparam logic [2:0] f3_lhu     = 3'b101;
    localparam logic [2:0] f3_sb      = 3'b000;
    localparam logic [2:0] f3_sh      = 3'b001;
    localparam logic [2:0] f3_sw      = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_blt     = 3'b100;
    localparam logic [2:0] f3_bge     = 3'b101;
    localparam logic [2:0] f3_bltu    = 3'b110;
    localparam logic [2:0] f3_bgeu    = 3'b111;
    localparam logic [2:0] f3_add_sub = 3'b000; // Shared by OP and OP-IMM.
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_fence   = 3'b000;
    localparam logic [2:0] f3_fence_i = 3'b001;
    localparam logic [2:0] f3_priv    = 3'b000;
    localparam logic [2:0] f3_csrrw   = 3'b001;
    localparam logic [2:0] f3_csrrs   = 3'b010;
    localparam logic [2:0] f3_csrrc   = 3'b011;
    localparam logic [2:0] f3_csrrwi  = 3'b101;
    localparam logic [2:0] f3_csrrsi  = 3'b110;
    localparam logic [2:0] f3_csrrci  = 3'b111;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    localparam logic [11:0] f12_ecall  = 12'h000;
    localparam logic [11:0] f12_ebreak = 12'h001;
    localparam logic [11:0] f12_mret   = 12'h302;
    localparam logic [11:0] f12_wfi    = 12'h105;

endpackage

/* tests/control_unit_patterns.txt */
// instr  legal  exec  access   (hex; exec and access are the packed control structs)
// exec: imm_fmt alu_op alu_sub_sra alu_src1 alu_src2 branch_op branch_pc_src, MSB first
002081B3 1 0000 3800 // add x3, x1, x2
402081B3 1 0080 3800 // sub x3, x1, x2
407352B3 1 0580 3800 // sra x5, x6, x7
00500093 1 0808 2800 // addi x1, x0, 5
4041D113 1 3588 2800 // srai x2, x3, 4
123452B7 1 2048 0800 // lui x5, 0x12345
00001317 1 2028 0800 // auipc x6, 1
008000EF 1 2836 0800 // jal x1, +8
000280E7 1 0837 2800 // jalr x1, 0(x5)
00208463 1 1882 3000 // beq x1, x2, +8
0020C463 1 1A84 3000 // blt x1, x2, +8
0020F463 1 1B82 3000 // bgeu x1, x2, +8
0040A283 1 0808 2D00 // lw x5, 4(x1)
0000C283 1 0808 2C40 // lbu x5, 0(x1)
00209323 1 1008 3280 // sh x2, 6(x1)
022081B3 0 0000 0000 // add with funct7 0000001
0000B283 0 0000 0000 // load funct3 3
0020A463 0 0000 0000 // branch funct3 2
FFFFFFFF 0 0000 0000 // unknown opcode
30009073 1 0000 2008 // csrrw x0, mstatus, x1
300092F3 1 0000 2818 // csrrw x5, mstatus, x1
3001D073 1 3800 0009 // csrrwi x0, mstatus, 3
300022F3 1 0000 2812 // csrrs x5, mstatus, x0
300272F3 1 3800 081D // csrrci x5, mstatus, 4
0FF0000F 1 0000 0000 // fence
0000100F 1 0000 0020 // fence.i
00000073 1 0000 0000 // ecall
00100073 1 0000 0000 // ebreak
30200073 1 0000 0000 // mret
10500073 1 0000 0000 // wfi

/* tests/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Reset is released on a falling edge so that no flop sees it change at its clock edge.
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* tests/tb_control_unit.sv */
`timescale 1ns/100ps

module tb_control_unit;
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    localparam int num_patterns   = 30;
    localparam int reset_cycles   = 8;
    localparam int timeout_cycles = num_patterns * 20 + reset_cycles;

    typedef struct packed {
        instr_t       instr;
        logic         legal;
        exec_ctrl_t   exec;
        access_ctrl_t access;
    } pattern_t;

    logic         clk;
    logic         rst_n;
    logic         instr_valid;
    instr_t       instr;
    logic         ctrl_valid;
    logic         ctrl_legal;
    exec_ctrl_t   exec;
    access_ctrl_t access;

    logic [31:0] raw [0:4*num_patterns-1]; // Four words per pattern line.
    pattern_t    patterns [0:num_patterns-1];
    pattern_t    pending [$];
    pattern_t    last = '0;  // Reset state until the first result.
    logic        strobe_seen = 1'b0;
    integer      seed;

    tb_clock_gen #(.period_ns(10), .reset_cycles(reset_cycles)) u_clock (
        .clk  (clk),
        .rst_n(rst_n)
    );

    control_unit DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_valid(instr_valid),
        .instr      (instr),
        .ctrl_valid (ctrl_valid),
        .ctrl_legal (ctrl_legal),
        .exec       (exec),
        .access     (access)
    );

    task automatic report_failure(input string msg);
        $display("FAILED at time %0d ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_legal(input logic got, input logic want, input instr_t word);
        if (got !== want)
            report_failure($sformatf("ctrl_legal for instr %h is %b, expected %b", word, got, want));
    endtask

    task automatic check_exec(input exec_ctrl_t got, input exec_ctrl_t want, input instr_t word);
        if (got !== want)
            report_failure($sformatf("exec controls for instr %h are %h, expected %h",
                                     word, got, want));
    endtask

    task automatic check_access(input access_ctrl_t got, input access_ctrl_t want,
                                input instr_t word);
        if (got !== want)
            report_failure($sformatf("access controls for instr %h are %h, expected %h",
                                     word, got, want));
    endtask

    task automatic load_patterns();
        $readmemh("tests/control_unit_patterns.txt", raw);
        for (int i = 0; i < num_patterns; i++) begin
            if ($isunknown(raw[4*i+3])) begin
                $display("The pattern file holds fewer than %0d complete lines", num_patterns);
                $display("Checks failed");
                $fatal(1, "pattern file incomplete");
            end
            patterns[i].instr  = raw[4*i];
            patterns[i].legal  = raw[4*i+1][0];
            patterns[i].exec   = exec_ctrl_t'(raw[4*i+2][13:0]);
            patterns[i].access = access_ctrl_t'(raw[4*i+3][13:0]);
        end
    endtask

    always @(posedge clk) strobe_seen <= instr_valid;

    // Stimulus. Random gaps of 0 to 2 cycles, with junk on instr while no strobe is given.
    initial begin
        int gap;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 77933;
        load_patterns();
        @(posedge rst_n);
        repeat (3) @(negedge clk);
        for (int i = 0; i < num_patterns; i++) begin
            @(negedge clk);
            instr_valid = 1'b1;
            instr       = patterns[i].instr;
            pending.push_back(patterns[i]);
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(negedge clk);
                instr_valid = 1'b0;
                instr       = $random(seed);
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;
        wait (pending.size() == 0);
        repeat (3) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

    // Outputs are sampled on the falling edge, half a cycle after they change.
    initial begin
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (ctrl_valid !== strobe_seen)
                report_failure($sformatf("ctrl_valid is %b one cycle after instr_valid %b",
                                         ctrl_valid, strobe_seen));
            if (ctrl_valid === 1'b1) begin
                last = pending.pop_front();
            end
            check_legal(ctrl_legal, last.legal, last.instr); // Held values must not move.
            check_exec(exec, last.exec, last.instr);
            check_access(access, last.access, last.instr);
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: ctrl_valid never arrived for every strobe within %0d cycles",
                 timeout_cycles);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule
